/* clk_synth_defines.svh */
`ifndef CLK_SYNTH_DEFINES_SVH
`define CLK_SYNTH_DEFINES_SVH

// bus and word widths
`define CS_WORD_W 32
`define CS_ADDR_W 5

// seventeen words per programming pass, control register right above them
`define CS_NUM_WORDS 17
`define CS_CTRL_ADDR 17

// start-up and sync timing, in slow_clk cycles
`define CS_DEFAULT_LOAD_CYCLES 32
`define CS_SYNC_LOW_CYCLES 16

// ****************************************
// default words in send order
// ****************************************
// chip R7 with reset bit set, then R0 to R6, R7 with reset cleared, R8 to R15
`define CS_DEF_WORD00 32'h8000_0017
`define CS_DEF_WORD01 32'h0000_0300
`define CS_DEF_WORD02 32'h0000_0301
`define CS_DEF_WORD03 32'h0000_0302
`define CS_DEF_WORD04 32'h0000_0303
`define CS_DEF_WORD05 32'h0000_0304
`define CS_DEF_WORD06 32'h0000_0305
`define CS_DEF_WORD07 32'h0000_0306
`define CS_DEF_WORD08 32'h0000_0017
`define CS_DEF_WORD09 32'h1000_0908
`define CS_DEF_WORD10 32'hA022_A009
`define CS_DEF_WORD11 32'h0082_000A
`define CS_DEF_WORD12 32'h0000_000B
`define CS_DEF_WORD13 32'h1B0C_006C
`define CS_DEF_WORD14 32'h2302_804D
`define CS_DEF_WORD15 32'h0000_001E
`define CS_DEF_WORD16 32'h0001_E00F

`endif

/* clk_synth_pkg.sv */
`include "clk_synth_defines.svh"

package clk_synth_pkg;

    // one configuration or bus data word
    typedef logic [`CS_WORD_W-1:0] synth_word_t;

    // bus address and word index into the register bank
    typedef logic [`CS_ADDR_W-1:0] word_addr_t;

    // ****************************************
    // state encodings
    // ****************************************

    // power-up sequencer, runs once per reset
    typedef enum logic [1:0] {
        su_wait,
        su_load,
        su_kick,
        su_done
    } startup_state_t;

    // word loop and sync pulse
    typedef enum logic [2:0] {
        wr_idle,
        wr_count,
        wr_load,
        wr_shift,
        wr_increment,
        wr_sync_low,
        wr_sync_high
    } write_state_t;

    // serial shifter
    typedef enum logic [1:0] {
        sh_idle,
        sh_load,
        sh_shifting
    } shift_state_t;

endpackage

/* clk_synth_reg_bank.sv */
`timescale 1ns/1ps
`include "clk_synth_defines.svh"

module clk_synth_reg_bank
(
    input  logic                      slow_clk,
    input  logic                      resetS,
    input  logic                      io_sel,
    input  logic                      io_wr_en,
    input  clk_synth_pkg::word_addr_t io_addr,
    input  clk_synth_pkg::synth_word_t io_wr_data,
    input  logic                      load_defaults,
    input  logic                      kick,
    input  clk_synth_pkg::word_addr_t word_addr,
    output clk_synth_pkg::synth_word_t word_data,
    output logic                      trigger_level
);

    // default table, index is the send order and not the chip register number
    localparam clk_synth_pkg::synth_word_t def_words [`CS_NUM_WORDS] = '{
        `CS_DEF_WORD00, `CS_DEF_WORD01, `CS_DEF_WORD02, `CS_DEF_WORD03,
        `CS_DEF_WORD04, `CS_DEF_WORD05, `CS_DEF_WORD06, `CS_DEF_WORD07,
        `CS_DEF_WORD08, `CS_DEF_WORD09, `CS_DEF_WORD10, `CS_DEF_WORD11,
        `CS_DEF_WORD12, `CS_DEF_WORD13, `CS_DEF_WORD14, `CS_DEF_WORD15,
        `CS_DEF_WORD16
    };

    localparam clk_synth_pkg::word_addr_t ctrl_addr =
        clk_synth_pkg::word_addr_t'(`CS_CTRL_ADDR);

    clk_synth_pkg::synth_word_t cfg_words [`CS_NUM_WORDS];
    logic                       wr_hit;
    // only bit 0 of the control register has a function
    logic                       ctrl_bit;

    // ****************************************
    // bus write decode
    // ****************************************
    // one cycle of select plus write enable is one write
    assign wr_hit = io_sel && io_wr_en;

    // configuration words, each address selects its own word
    always_ff @(posedge slow_clk)
    begin
        if (resetS || load_defaults)
        begin
            cfg_words <= def_words;
        end
        else if (wr_hit && (io_addr < `CS_NUM_WORDS))
        begin
            cfg_words[io_addr] <= io_wr_data;
        end
    end

    // control register
    // kick from the start-up sequencer wins over a bus write in the same cycle
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            ctrl_bit <= 1'b0;
        end
        else if (kick)
        begin
            ctrl_bit <= 1'b1;
        end
        else if (wr_hit && (io_addr == ctrl_addr))
        begin
            ctrl_bit <= io_wr_data[0];
        end
    end

    assign trigger_level = ctrl_bit;

    // ****************************************
    // word read-out for the write controller
    // ****************************************
    // one cycle behind word_addr, out-of-range index reads zero
    always_ff @(posedge slow_clk)
    begin
        if (word_addr < `CS_NUM_WORDS)
        begin
            word_data <= cfg_words[word_addr];
        end
        else
        begin
            word_data <= '0;
        end
    end

endmodule

/* clk_synth_startup.sv */
`timescale 1ns/1ps
`include "clk_synth_defines.svh"

module clk_synth_startup
#(
    parameter int startup_wait_cycles = 400000
)
(
    input  logic slow_clk,
    input  logic resetS,
    output logic load_defaults,
    output logic kick,
    output logic startup_done
);

    clk_synth_pkg::startup_state_t state;
    // shared by the wait and the load window
    logic [31:0]                   cnt;

    // ****************************************
    // one-pass sequencer
    // ****************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state <= clk_synth_pkg::su_wait;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                // chip needs its supplies settled before anything is sent
                clk_synth_pkg::su_wait:
                begin
                    cnt <= cnt + 32'd1;
                    if (cnt == 32'(startup_wait_cycles - 1))
                    begin
                        cnt   <= '0;
                        state <= clk_synth_pkg::su_load;
                    end
                end
                // register bank forced to defaults for the whole window
                clk_synth_pkg::su_load:
                begin
                    cnt <= cnt + 32'd1;
                    if (cnt == 32'(`CS_DEFAULT_LOAD_CYCLES - 1))
                    begin
                        cnt   <= '0;
                        state <= clk_synth_pkg::su_kick;
                    end
                end
                // sets control bit 0, which starts the first pass
                clk_synth_pkg::su_kick:
                begin
                    state <= clk_synth_pkg::su_done;
                end
                // parked until the next reset
                default:
                begin
                    state <= clk_synth_pkg::su_done;
                end
            endcase
        end
    end

    // outputs decoded straight from the state register
    assign load_defaults = (state == clk_synth_pkg::su_load);
    assign kick          = (state == clk_synth_pkg::su_kick);
    assign startup_done  = (state == clk_synth_pkg::su_done);

endmodule

/* clk_synth_write_ctrl.sv */
`timescale 1ns/1ps
`include "clk_synth_defines.svh"

module clk_synth_write_ctrl
(
    input  logic                      slow_clk,
    input  logic                      resetS,
    input  logic                      trigger_level,
    input  logic                      startup_done,
    input  logic                      ready,
    output clk_synth_pkg::word_addr_t word_addr,
    output logic                      load_strobe,
    output logic                      sync
);

    typedef enum logic [1:0] {
        edge_idle,
        edge_fire,
        edge_held
    } edge_state_t;

    localparam int sync_cnt_w = $clog2(`CS_SYNC_LOW_CYCLES);
    localparam logic [sync_cnt_w-1:0] sync_last = sync_cnt_w'(`CS_SYNC_LOW_CYCLES - 1);
    localparam clk_synth_pkg::word_addr_t loop_max =
        clk_synth_pkg::word_addr_t'(`CS_NUM_WORDS);

    logic                          trig_q;
    edge_state_t                   edge_state;
    logic                          trigger;
    clk_synth_pkg::word_addr_t     loop_cnt;
    logic                          loop_cnt_ena;
    logic                          loop_done;
    clk_synth_pkg::write_state_t   state;
    logic [sync_cnt_w-1:0]         sync_cnt;
    // high while no sync pulse is owed for the current pass
    logic                          sync_given;

    // ****************************************
    // trigger edge detect
    // ****************************************
    always_ff @(posedge slow_clk)
    begin
        trig_q <= trigger_level;
    end

    // fires once per rise, then waits for the bit to drop
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            edge_state <= edge_idle;
        end
        else
        begin
            case (edge_state)
                edge_idle:
                begin
                    if (trig_q)
                    begin
                        edge_state <= edge_fire;
                    end
                end
                edge_fire:
                begin
                    edge_state <= edge_held;
                end
                default:
                begin
                    if (!trig_q)
                    begin
                        edge_state <= edge_idle;
                    end
                end
            endcase
        end
    end

    assign trigger = (edge_state == edge_fire);

    // ****************************************
    // word loop counter
    // ****************************************
    // parked at the end so reset alone starts no pass
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            loop_cnt <= loop_max;
        end
        else if (trigger)
        begin
            loop_cnt <= '0;
        end
        else if (loop_cnt_ena)
        begin
            loop_cnt <= loop_cnt + 1'b1;
        end
    end

    assign loop_done    = (loop_cnt == loop_max);
    assign loop_cnt_ena = (state == clk_synth_pkg::wr_count);

    // ****************************************
    // write FSM
    // ****************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state      <= clk_synth_pkg::wr_idle;
            word_addr  <= '0;
            sync_cnt   <= '0;
            sync_given <= 1'b1;
        end
        else
        begin
            case (state)
                clk_synth_pkg::wr_idle:
                begin
                    sync_cnt <= '0;
                    if (!loop_done)
                    begin
                        state <= clk_synth_pkg::wr_count;
                    end
                    else
                    begin
                        word_addr <= '0;
                        // no sync before start-up has finished
                        if (!sync_given && startup_done)
                        begin
                            state <= clk_synth_pkg::wr_sync_low;
                        end
                    end
                end
                clk_synth_pkg::wr_count:
                begin
                    sync_given <= 1'b0;
                    state      <= clk_synth_pkg::wr_load;
                end
                // strobe held until the serializer takes the word
                clk_synth_pkg::wr_load:
                begin
                    if (!ready)
                    begin
                        state <= clk_synth_pkg::wr_shift;
                    end
                end
                // wait out the 32-bit frame
                clk_synth_pkg::wr_shift:
                begin
                    if (ready)
                    begin
                        state <= clk_synth_pkg::wr_increment;
                    end
                end
                clk_synth_pkg::wr_increment:
                begin
                    word_addr <= word_addr + 1'b1;
                    state     <= clk_synth_pkg::wr_idle;
                end
                clk_synth_pkg::wr_sync_low:
                begin
                    sync_cnt <= sync_cnt + 1'b1;
                    if (sync_cnt == sync_last)
                    begin
                        sync_cnt <= '0;
                        state    <= clk_synth_pkg::wr_sync_high;
                    end
                end
                // minimum high time before another pass can start
                clk_synth_pkg::wr_sync_high:
                begin
                    sync_cnt <= sync_cnt + 1'b1;
                    if (sync_cnt == sync_last)
                    begin
                        sync_given <= 1'b1;
                        state      <= clk_synth_pkg::wr_idle;
                    end
                end
                default:
                begin
                    state <= clk_synth_pkg::wr_idle;
                end
            endcase
        end
    end

    assign load_strobe = (state == clk_synth_pkg::wr_load);
    assign sync        = (state != clk_synth_pkg::wr_sync_low);

endmodule

/* clk_synth_serializer.sv */
`timescale 1ns/1ps
`include "clk_synth_defines.svh"

module clk_synth_serializer
(
    input  logic                       slow_clk,
    input  logic                       resetS,
    input  logic                       load_strobe,
    input  clk_synth_pkg::synth_word_t word_data,
    output logic                       ddat,
    output logic                       dlen,
    output logic                       ready
);

    localparam int bit_cnt_w = $clog2(`CS_WORD_W);
    localparam logic [bit_cnt_w-1:0] bit_last = bit_cnt_w'(`CS_WORD_W - 1);

    clk_synth_pkg::shift_state_t state;
    clk_synth_pkg::synth_word_t  sreg;
    logic [bit_cnt_w-1:0]        bit_cnt;

    // ****************************************
    // shift FSM and bit counter
    // ****************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state   <= clk_synth_pkg::sh_idle;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                clk_synth_pkg::sh_idle:
                begin
                    bit_cnt <= '0;
                    if (load_strobe)
                    begin
                        state <= clk_synth_pkg::sh_load;
                    end
                end
                // frame starts once the strobe is released
                clk_synth_pkg::sh_load:
                begin
                    if (!load_strobe)
                    begin
                        state <= clk_synth_pkg::sh_shifting;
                    end
                end
                clk_synth_pkg::sh_shifting:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == bit_last)
                    begin
                        state <= clk_synth_pkg::sh_idle;
                    end
                end
                default:
                begin
                    state <= clk_synth_pkg::sh_idle;
                end
            endcase
        end
    end

    // tracks word_data until the frame starts, then msb first
    always_ff @(posedge slow_clk)
    begin
        if (state == clk_synth_pkg::sh_shifting)
        begin
            sreg <= {sreg[`CS_WORD_W-2:0], 1'b0};
        end
        else
        begin
            sreg <= word_data;
        end
    end

    assign ddat  = sreg[`CS_WORD_W-1];
    // dlen low for exactly the 32 shifting cycles
    assign dlen  = (state != clk_synth_pkg::sh_shifting);
    assign ready = (state == clk_synth_pkg::sh_idle);

endmodule

/* clk_synth_top.sv */
`timescale 1ns/1ps

module clk_synth_top
#(
    parameter int startup_wait_cycles = 400000
)
(
    input  logic                       slow_clk,
    input  logic                       resetS,
    input  logic                       io_sel,
    input  logic                       io_wr_en,
    input  clk_synth_pkg::word_addr_t  io_addr,
    input  clk_synth_pkg::synth_word_t io_wr_data,
    output logic                       ddat,
    output logic                       dlen,
    output logic                       sync
);

    // start-up controls
    logic                       load_defaults;
    logic                       kick;
    logic                       startup_done;
    // register bank to write controller
    logic                       trigger_level;
    clk_synth_pkg::word_addr_t  word_addr;
    clk_synth_pkg::synth_word_t word_data;
    // write controller to serializer handshake
    logic                       load_strobe;
    logic                       ready;

    clk_synth_reg_bank i_reg_bank (
        .slow_clk      (slow_clk),
        .resetS        (resetS),
        .io_sel        (io_sel),
        .io_wr_en      (io_wr_en),
        .io_addr       (io_addr),
        .io_wr_data    (io_wr_data),
        .load_defaults (load_defaults),
        .kick          (kick),
        .word_addr     (word_addr),
        .word_data     (word_data),
        .trigger_level (trigger_level)
    );

    clk_synth_startup #(
        .startup_wait_cycles (startup_wait_cycles)
    ) i_startup (
        .slow_clk      (slow_clk),
        .resetS        (resetS),
        .load_defaults (load_defaults),
        .kick          (kick),
        .startup_done  (startup_done)
    );

    clk_synth_write_ctrl i_write_ctrl (
        .slow_clk      (slow_clk),
        .resetS        (resetS),
        .trigger_level (trigger_level),
        .startup_done  (startup_done),
        .ready         (ready),
        .word_addr     (word_addr),
        .load_strobe   (load_strobe),
        .sync          (sync)
    );

    clk_synth_serializer i_serializer (
        .slow_clk    (slow_clk),
        .resetS      (resetS),
        .load_strobe (load_strobe),
        .word_data   (word_data),
        .ddat        (ddat),
        .dlen        (dlen),
        .ready       (ready)
    );

endmodule

/* tb_clk_synth.sv */
`timescale 1ns/1ps
`include "clk_synth_defines.svh"

module tb_clk_synth;

    localparam int wait_cycles = 64;
    // generous bound for a full pass of seventeen frames
    localparam int pass_limit  = 3000;

    logic                       slow_clk;
    logic                       resetS;
    logic                       io_sel;
    logic                       io_wr_en;
    clk_synth_pkg::word_addr_t  io_addr;
    clk_synth_pkg::synth_word_t io_wr_data;
    logic                       ddat;
    logic                       dlen;
    logic                       sync;

    // expected words in send order
    clk_synth_pkg::synth_word_t model_words [`CS_NUM_WORDS];
    // collected frames and sync pulse lengths
    clk_synth_pkg::synth_word_t frames [$];
    int                         sync_lens [$];
    int                         frames_at_sync [$];
    clk_synth_pkg::synth_word_t shift_in;
    int                         bit_cnt;
    logic                       prev_dlen;
    int                         low_cnt;
    logic [31:0]                lfsr_state;
    int                         checks;
    int                         errors;
    int                         timeouts;
    bit                         aborted;

    clk_synth_top #(
        .startup_wait_cycles (wait_cycles)
    ) i_dut (
        .slow_clk   (slow_clk),
        .resetS     (resetS),
        .io_sel     (io_sel),
        .io_wr_en   (io_wr_en),
        .io_addr    (io_addr),
        .io_wr_data (io_wr_data),
        .ddat       (ddat),
        .dlen       (dlen),
        .sync       (sync)
    );

    // 4 ns period
    always #2 slow_clk = ~slow_clk;

    // ****************************************
    // monitors sampled at the falling edge
    // ****************************************
    // frame collector with the msb arriving first
    always @(negedge slow_clk)
    begin
        if (resetS)
            bit_cnt = 0;
        else if (!dlen)
        begin
            // a new frame has to follow a high dlen cycle
            if (bit_cnt == 0 && !prev_dlen)
            begin
                $display("dlen stayed low for more than %0d cycles", `CS_WORD_W);
                errors++;
            end
            shift_in = {shift_in[`CS_WORD_W-2:0], ddat};
            bit_cnt++;
            if (bit_cnt == `CS_WORD_W)
            begin
                frames.push_back(shift_in);
                bit_cnt = 0;
            end
        end
        else if (bit_cnt != 0)
        begin
            $display("dlen rose after only %0d bits of a frame", bit_cnt);
            errors++;
            bit_cnt = 0;
        end
        prev_dlen = dlen;
    end

    // sync low time is logged when sync rises again
    always @(negedge slow_clk)
    begin
        if (resetS)
            low_cnt = 0;
        else if (!sync)
            low_cnt++;
        else if (low_cnt != 0)
        begin
            sync_lens.push_back(low_cnt);
            frames_at_sync.push_back(frames.size());
            low_cnt = 0;
        end
    end

    // ****************************************
    // helpers
    // ****************************************
    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = next_lfsr(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic load_default_model;
        model_words = '{
            `CS_DEF_WORD00, `CS_DEF_WORD01, `CS_DEF_WORD02, `CS_DEF_WORD03,
            `CS_DEF_WORD04, `CS_DEF_WORD05, `CS_DEF_WORD06, `CS_DEF_WORD07,
            `CS_DEF_WORD08, `CS_DEF_WORD09, `CS_DEF_WORD10, `CS_DEF_WORD11,
            `CS_DEF_WORD12, `CS_DEF_WORD13, `CS_DEF_WORD14, `CS_DEF_WORD15,
            `CS_DEF_WORD16
        };
    endtask

    // one bus cycle and then the bus goes idle
    task automatic bus_write(input logic [4:0] addr, input logic [31:0] data,
                             input logic sel, input logic wr_en);
        @(posedge slow_clk);
        io_sel     <= sel;
        io_wr_en   <= wr_en;
        io_addr    <= addr;
        io_wr_data <= data;
        @(posedge slow_clk);
        io_sel   <= 1'b0;
        io_wr_en <= 1'b0;
        // model takes only accepted writes to a config word
        if (sel && wr_en && addr < `CS_NUM_WORDS)
            model_words[addr] = data;
    endtask

    // resetS is already high and four edges see it
    task automatic hold_reset;
        int i;
        for (i = 0; i < 4; i++)
        begin
            @(posedge slow_clk);
            if (i == 3)
                resetS <= 1'b0;
            @(negedge slow_clk);
            check_value("reset dlen", 1, dlen);
            check_value("reset sync", 1, sync);
        end
    endtask

    task automatic wait_frames(input string name, input int count);
        int cycles;
        cycles = 0;
        while (frames.size() < count && cycles < pass_limit)
        begin
            @(negedge slow_clk);
            cycles++;
        end
        if (frames.size() < count)
        begin
            $display("timeout: %s got %0d of %0d frames", name, frames.size(), count);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_sync_pulse(input string name);
        int cycles;
        cycles = 0;
        while (sync_lens.size() == 0 && cycles < 200)
        begin
            @(negedge slow_clk);
            cycles++;
        end
        if (sync_lens.size() == 0)
        begin
            $display("timeout: %s saw no sync pulse after the last frame", name);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_dlen_low(input string name, output int cycles);
        cycles = 0;
        @(negedge slow_clk);
        while (dlen === 1'b1 && cycles < pass_limit)
        begin
            // sync must not pulse before any frame
            if (sync !== 1'b1)
                check_value({name, " sync before frame"}, 1, sync);
            cycles++;
            @(negedge slow_clk);
        end
        if (dlen === 1'b1)
        begin
            $display("timeout: %s, dlen never went low", name);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    // nothing may arrive between passes
    task automatic check_quiet(input string name);
        check_value({name, " extra frames"}, 0, frames.size());
        check_value({name, " extra sync pulses"}, 0, sync_lens.size());
    endtask

    task automatic check_pass(input string name);
        int i;
        check_value({name, " frame count"}, `CS_NUM_WORDS, frames.size());
        for (i = 0; i < `CS_NUM_WORDS && i < frames.size(); i++)
            check_value($sformatf("%s word %0d", name, i), model_words[i], frames[i]);
        check_value({name, " sync low cycles"}, `CS_SYNC_LOW_CYCLES, sync_lens[0]);
        check_value({name, " frames before sync"}, `CS_NUM_WORDS, frames_at_sync[0]);
        frames.delete();
        sync_lens.delete();
        frames_at_sync.delete();
    endtask

    // ****************************************
    // tests
    // ****************************************
    // quiet start-up right after reset and then the default pass
    task automatic run_default_pass(input string name);
        int idle;
        wait_dlen_low(name, idle);
        if (aborted)
            return;
        check_value({name, " idle at least wait"}, 1, 32'(idle >= wait_cycles));
        wait_frames(name, `CS_NUM_WORDS);
        if (aborted)
            return;
        wait_sync_pulse(name);
        if (aborted)
            return;
        check_pass(name);
    endtask

    task automatic test_reprogram;
        int          i;
        logic [4:0]  addr;
        logic [31:0] data;
        logic        sel;
        logic        wr_en;
        for (i = 0; i < 48; i++)
        begin
            addr  = 5'(rand_bits(5));
            data  = rand_bits(32);
            sel   = rand_bits(1) != 0 || rand_bits(1) != 0;
            wr_en = rand_bits(1) != 0 || rand_bits(1) != 0;
            // control writes keep bit 0 clear so no pass starts early
            if (addr == `CS_CTRL_ADDR)
                data[0] = 1'b0;
            bus_write(addr, data, sel, wr_en);
        end
        // the previous pass must have ended with its single sync pulse
        check_quiet("reprogram");
        bus_write(`CS_CTRL_ADDR, 32'd0, 1'b1, 1'b1);
        bus_write(`CS_CTRL_ADDR, 32'd1, 1'b1, 1'b1);
        wait_frames("reprogram", `CS_NUM_WORDS);
        if (aborted)
            return;
        wait_sync_pulse("reprogram");
        if (aborted)
            return;
        check_pass("reprogram");
    endtask

    // control bit is already high so a second 1 must not retrigger
    task automatic test_held_trigger;
        int i;
        bit low_seen;
        bus_write(`CS_CTRL_ADDR, 32'd1, 1'b1, 1'b1);
        low_seen = 1'b0;
        for (i = 0; i < 2000; i++)
        begin
            @(negedge slow_clk);
            if (dlen !== 1'b1)
                low_seen = 1'b1;
        end
        check_value("held trigger dlen low", 0, 32'(low_seen));
        check_quiet("held trigger end");
    endtask

    task automatic test_reset_mid_pass;
        int idle;
        bus_write(`CS_CTRL_ADDR, 32'd0, 1'b1, 1'b1);
        bus_write(`CS_CTRL_ADDR, 32'd1, 1'b1, 1'b1);
        wait_dlen_low("reset mid-pass", idle);
        if (aborted)
            return;
        // part way into the first frame
        repeat (10) @(posedge slow_clk);
        resetS <= 1'b1;
        hold_reset();
        frames.delete();
        sync_lens.delete();
        frames_at_sync.delete();
        load_default_model();
        run_default_pass("reset mid-pass defaults");
    endtask

    initial
    begin
        slow_clk   = 1'b0;
        resetS     = 1'b1;
        io_sel     = 1'b0;
        io_wr_en   = 1'b0;
        io_addr    = '0;
        io_wr_data = '0;
        lfsr_state = 32'd80570;
        shift_in   = '0;
        bit_cnt    = 0;
        prev_dlen  = 1'b1;
        low_cnt    = 0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        aborted    = 1'b0;
        load_default_model();
        hold_reset();
        run_default_pass("default pass");
        if (!aborted)
            test_reprogram();
        if (!aborted)
            test_held_trigger();
        if (!aborted)
            test_reset_mid_pass();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
clk_synth_pkg.sv
clk_synth_reg_bank.sv
clk_synth_startup.sv
clk_synth_write_ctrl.sv
clk_synth_serializer.sv
clk_synth_top.sv
tb_clk_synth.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_clk_synth -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_clk_synth)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1
